//--- verilog/icache_cfg_pkg.sv
`default_nettype none

package icache_cfg_pkg;

	// 2-way, 128 sets, 32-byte lines
	localparam int ADDR_W   = 64;
	localparam int WORD_W   = 64;
	localparam int OFFSET_W = 5;   // byte offset inside a line
	localparam int INDEX_W  = 7;
	localparam int SETS     = 128;
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;  // 52
	localparam int BEATS    = 4;   // words per line

	typedef logic [ADDR_W-1:0]          addr_t;
	typedef logic [WORD_W-1:0]          word_t;
	typedef logic [TAG_W-1:0]           tag_t;
	typedef logic [INDEX_W-1:0]         index_t;
	typedef logic [$clog2(BEATS)-1:0]   beat_t;

endpackage

`default_nettype wire

//--- verilog/icache_bus_pkg.sv
`default_nettype none

package icache_bus_pkg;

	import icache_cfg_pkg::*;

	// cpu side, single-cycle strobes
	typedef struct packed {
		logic  valid;
		addr_t addr;   // byte address
	} cpu_req_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} cpu_rsp_t;

	// memory side, one line per request
	typedef struct packed {
		logic  valid;
		addr_t addr;   // line aligned
	} mem_req_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} mem_beat_t;

endpackage

`default_nettype wire

//--- verilog/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
	import icache_cfg_pkg::*;
	import icache_bus_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  cpu_req_t   cpu_req,
	input  wire        flush,
	input  wire        hit,
	input  wire        hit_way,
	input  wire        victim_way,
	input  wire        refill_done,
	input  word_t      rd_word,
	output cpu_rsp_t   cpu_rsp,
	output index_t     index,
	output tag_t       tag,
	output beat_t      word_sel,
	output logic       sel_way,
	output logic       fill_we,
	output logic       touch,
	output logic       flush_all,
	output logic       refill_start,
	output addr_t      line_addr
);

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		REFILL
	} state_t;

	state_t state;
	state_t state_nxt;
	addr_t  addr_q;
	logic   victim_q;
	logic   rsp_valid_q;
	word_t  rsp_data_q;

	// fields of the captured address
	assign index     = addr_q[OFFSET_W +: INDEX_W];
	assign tag       = addr_q[ADDR_W-1 -: TAG_W];
	assign word_sel  = addr_q[OFFSET_W-1 -: $bits(beat_t)];
	assign line_addr = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

	assign touch        = (state == LOOKUP) && hit;
	assign refill_start = (state == LOOKUP) && !hit;
	assign fill_we      = (state == REFILL) && refill_done;  // tag install with the last beat
	assign flush_all    = (state == IDLE) && flush;

	// hit way on lookup, latched victim while refilling
	assign sel_way = (state == REFILL) ? victim_q : hit_way;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:   if (cpu_req.valid) state_nxt = LOOKUP;
			LOOKUP: state_nxt = hit ? IDLE : REFILL;
			REFILL: if (refill_done) state_nxt = LOOKUP;  // repeat the lookup
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= IDLE;
			rsp_valid_q <= 1'b0;
		end else begin
			state       <= state_nxt;
			rsp_valid_q <= touch;
		end
	end

	always_ff @(posedge clk) begin
		if ((state == IDLE) && cpu_req.valid)
			addr_q <= cpu_req.addr;
		if (refill_start)
			victim_q <= victim_way;
		if (touch)
			rsp_data_q <= rd_word;
	end

	assign cpu_rsp.valid = rsp_valid_q;
	assign cpu_rsp.data  = rsp_data_q;

endmodule

`default_nettype wire

//--- verilog/icache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array
	import icache_cfg_pkg::*;
(
	input  wire     clk,
	input  wire     rst_n,
	input  index_t  index,
	input  tag_t    tag,
	input  wire     fill_we,
	input  wire     fill_way,
	input  wire     touch,
	input  wire     touch_way,
	input  wire     flush_all,
	output logic    hit,
	output logic    hit_way,
	output logic    victim_way
);

	logic [1:0]    valid_q [SETS];
	tag_t          tag_q   [SETS][2];
	logic [SETS-1:0] lru_q;     // way to replace next
	logic          hit0;
	logic          hit1;

	// both ways compared in parallel
	assign hit0    = valid_q[index][0] && (tag_q[index][0] == tag);
	assign hit1    = valid_q[index][1] && (tag_q[index][1] == tag);
	assign hit     = hit0 || hit1;
	assign hit_way = hit1;

	always_comb begin
		if (!valid_q[index][0])
			victim_way = 1'b0;
		else if (!valid_q[index][1])
			victim_way = 1'b1;
		else
			victim_way = lru_q[index];
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush_all) begin
			for (int s = 0; s < SETS; s++)
				valid_q[s] <= 2'b00;
		end else if (fill_we) begin
			valid_q[index][fill_way] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			lru_q <= '0;
		else if (fill_we)
			lru_q[index] <= ~fill_way;   // other way becomes lru
		else if (touch)
			lru_q[index] <= ~touch_way;
	end

	always_ff @(posedge clk) begin
		if (fill_we)
			tag_q[index][fill_way] <= tag;
	end

endmodule

`default_nettype wire

//--- verilog/icache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_data_array
	import icache_cfg_pkg::*;
(
	input  wire     clk,
	input  index_t  index,
	input  wire     way,
	input  wire     beat_we,
	input  beat_t   beat_idx,
	input  word_t   beat_data,
	input  beat_t   word_sel,
	output word_t   rd_word
);

	// four words per way per set
	word_t mem [SETS][2][BEATS];

	always_ff @(posedge clk) begin
		if (beat_we)
			mem[index][way][beat_idx] <= beat_data;
	end

	// async read, registered in ctrl
	assign rd_word = mem[index][way][word_sel];

endmodule

`default_nettype wire

//--- verilog/icache_refill.sv
`timescale 1ns/10ps
`default_nettype none

module icache_refill
	import icache_cfg_pkg::*;
	import icache_bus_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire        refill_start,
	input  addr_t      line_addr,
	input  mem_beat_t  mem_beat,
	output mem_req_t   mem_req,
	output logic       beat_we,
	output beat_t      beat_idx,
	output word_t      beat_data,
	output logic       refill_done
);

	logic  busy;
	beat_t cnt;
	logic  req_valid_q;
	addr_t req_addr_q;

	// beats are only taken while a line is pending
	assign beat_we     = mem_beat.valid && busy;
	assign beat_idx    = cnt;
	assign beat_data   = mem_beat.data;
	assign refill_done = beat_we && (cnt == beat_t'(BEATS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy        <= 1'b0;
			cnt         <= '0;
			req_valid_q <= 1'b0;
		end else begin
			req_valid_q <= refill_start;   // one cycle after start
			if (refill_start) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (beat_we) begin
				cnt <= cnt + 1'b1;
				if (refill_done)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (refill_start)
			req_addr_q <= line_addr;
	end

	assign mem_req.valid = req_valid_q;
	assign mem_req.addr  = req_addr_q;

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top
	import icache_cfg_pkg::*;
	import icache_bus_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  cpu_req_t   cpu_req,
	input  wire        flush,
	input  mem_beat_t  mem_beat,
	output cpu_rsp_t   cpu_rsp,
	output mem_req_t   mem_req
);

	logic   hit, hit_way, victim_way;
	logic   sel_way, fill_we, touch, flush_all;
	logic   refill_start, refill_done, beat_we;
	index_t index;
	tag_t   tag;
	beat_t  word_sel, beat_idx;
	addr_t  line_addr;
	word_t  rd_word, beat_data;

	icache_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.cpu_req      (cpu_req),
		.flush        (flush),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.refill_done  (refill_done),
		.rd_word      (rd_word),
		.cpu_rsp      (cpu_rsp),
		.index        (index),
		.tag          (tag),
		.word_sel     (word_sel),
		.sel_way      (sel_way),
		.fill_we      (fill_we),
		.touch        (touch),
		.flush_all    (flush_all),
		.refill_start (refill_start),
		.line_addr    (line_addr)
	);

	// fill and touch both follow sel_way
	icache_tag_array u_tags (
		.clk        (clk),
		.rst_n      (rst_n),
		.index      (index),
		.tag        (tag),
		.fill_we    (fill_we),
		.fill_way   (sel_way),
		.touch      (touch),
		.touch_way  (sel_way),
		.flush_all  (flush_all),
		.hit        (hit),
		.hit_way    (hit_way),
		.victim_way (victim_way)
	);

	icache_data_array u_data (
		.clk       (clk),
		.index     (index),
		.way       (sel_way),
		.beat_we   (beat_we),
		.beat_idx  (beat_idx),
		.beat_data (beat_data),
		.word_sel  (word_sel),
		.rd_word   (rd_word)
	);

	icache_refill u_refill (
		.clk          (clk),
		.rst_n        (rst_n),
		.refill_start (refill_start),
		.line_addr    (line_addr),
		.mem_beat     (mem_beat),
		.mem_req      (mem_req),
		.beat_we      (beat_we),
		.beat_idx     (beat_idx),
		.beat_data    (beat_data),
		.refill_done  (refill_done)
	);

endmodule

`default_nettype wire

//--- verification/icache_props.sv
`timescale 1ns/10ps
`default_nettype none

module icache_props
	import icache_bus_pkg::*;
(
	input wire           clk,
	input wire           rst_n,
	input wire cpu_req_t cpu_req,
	input wire cpu_rsp_t cpu_rsp,
	input wire mem_req_t mem_req
);

	logic       pending;  // accepted, not yet answered
	logic [1:0] nreq;     // line requests since the cpu request

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= 1'b0;
			nreq    <= '0;
		end else begin
			if (mem_req.valid && nreq != 2'd3)
				nreq <= nreq + 1'b1;
			if (cpu_req.valid) begin
				pending <= 1'b1;
				nreq    <= '0;
			end else if (cpu_rsp.valid) begin
				pending <= 1'b0;
			end
		end
	end

	rsp_single: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_rsp.valid |=> !cpu_rsp.valid)
		else $error("cpu_rsp.valid high for more than one cycle");

	mem_req_single: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req.valid |=> !mem_req.valid)
		else $error("mem_req.valid high for more than one cycle");

	no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_req.valid |-> !pending)
		else $error("cpu request while another is outstanding");

	one_line_req: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req.valid |-> (pending && nreq == 2'd0))
		else $error("extra or stray memory request");

endmodule

bind icache_top icache_props u_props (
	.clk     (clk),
	.rst_n   (rst_n),
	.cpu_req (cpu_req),
	.cpu_rsp (cpu_rsp),
	.mem_req (mem_req)
);

`default_nettype wire

//--- verification/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb
	import icache_cfg_pkg::*;
	import icache_bus_pkg::*;
();

	localparam int unsigned SEED = 32'h7ff1_b6b2;
	localparam int RSP_TIMEOUT = 60;  // worst refill is about 20 cycles
	localparam word_t MEM_KEY = 64'h9e37_79b9_7f4a_7c15;
	localparam addr_t BASE = 64'h0000_4000_0000_1000;

	typedef struct packed {
		addr_t       addr;
		logic        miss;
		word_t       data;
		logic [31:0] req_cyc;
	} expect_t;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      flush;
	cpu_req_t  cpu_req;
	cpu_rsp_t  cpu_rsp;
	mem_req_t  mem_req;
	mem_beat_t mem_beat;

	int          errors;
	int          checks;
	int          miss_seen;   // mem_req strobes since the last response
	logic [31:0] cyc;
	logic [31:0] last_beat_cyc;
	expect_t     exp_q[$];
	expect_t     rsp_e;

	addr_t beat_addr;
	int    beats_left;
	int    gap;

	// two-way lru model of the cache
	logic [1:0] m_valid [SETS];
	tag_t       m_tag   [SETS][2];
	logic       m_lru   [SETS];

	icache_top UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.cpu_req  (cpu_req),
		.flush    (flush),
		.mem_beat (mem_beat),
		.cpu_rsp  (cpu_rsp),
		.mem_req  (mem_req)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// word address rotated, then xor
	function automatic word_t mem_word(addr_t a);
		word_t wa;
		wa = a >> 3;
		return ((wa << 13) | (wa >> 51)) ^ MEM_KEY;
	endfunction

	function automatic expect_t ref_access(addr_t a);
		expect_t e;
		index_t  idx;
		tag_t    t;
		logic    way;
		idx = a[11:5];
		t = a[63:12];
		e.addr = a;
		e.data = mem_word(a);
		e.req_cyc = '0;
		e.miss = 1'b1;
		way = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == t) begin
				e.miss = 1'b0;
				way = w[0];
			end
		end
		if (e.miss) begin
			if (!m_valid[idx][0])
				way = 1'b0;
			else if (!m_valid[idx][1])
				way = 1'b1;
			else
				way = m_lru[idx];
			m_valid[idx][way] = 1'b1;
			m_tag[idx][way] = t;
		end
		m_lru[idx] = ~way;
		return e;
	endfunction

	function automatic addr_t set_addr(int k);
		return {52'(k + 1), 7'h2a, 5'h08};  // same set, distinct tags
	endfunction

	task automatic check(string name, logic [63:0] got, logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	task automatic wait_rsp(addr_t a);
		int n;
		n = 0;
		while (cpu_rsp.valid !== 1'b1 && n < RSP_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (cpu_rsp.valid !== 1'b1) begin
			$display("no response for address %h within %0d cycles", a, RSP_TIMEOUT);
			errors++;
			finish_run();
		end
	endtask

	task automatic access(addr_t a);
		expect_t e;
		@(negedge clk);
		flush = 1'b0;  // flush strobe lasts one cycle
		e = ref_access(a);
		e.req_cyc = cyc;
		exp_q.push_back(e);
		cpu_req.valid = 1'b1;
		cpu_req.addr = a;
		@(negedge clk);
		cpu_req.valid = 1'b0;
		wait_rsp(a);
	endtask

	// next access lands in the cycle right after the strobe
	task automatic do_flush();
		@(negedge clk);
		flush = 1'b1;
		for (int s = 0; s < SETS; s++)
			m_valid[s] = 2'b00;  // lru bits survive a flush
	endtask

	// memory model, four beats after a random gap
	always @(negedge clk) begin
		mem_beat.valid = 1'b0;
		if (mem_req.valid === 1'b1) begin
			beat_addr = mem_req.addr;
			beats_left = BEATS;
			gap = $urandom_range(0, 3);
		end else if (beats_left > 0) begin
			if (gap > 0) begin
				gap--;
			end else begin
				mem_beat.valid = 1'b1;
				mem_beat.data = mem_word(beat_addr);
				beat_addr += 8;
				beats_left--;
				gap = $urandom_range(0, 2);
				if (beats_left == 0)
					last_beat_cyc = cyc;
			end
		end
	end

	// compare responses and line requests against the model
	always @(negedge clk) begin
		if (rst_n === 1'b1 && ($isunknown(cpu_rsp.valid) || $isunknown(mem_req.valid))) begin
			$display("unknown value on a response or memory request strobe");
			errors++;
		end
		if (mem_req.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("memory request seen with no CPU request outstanding");
				errors++;
			end else begin
				check("mem_req.addr", mem_req.addr, {exp_q[0].addr[63:5], 5'b0});
				check("mem_req delay", cyc - exp_q[0].req_cyc, 2);
				miss_seen++;
			end
		end
		if (cpu_rsp.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("response seen with no CPU request outstanding");
				errors++;
			end else begin
				rsp_e = exp_q.pop_front();
				check("cpu_rsp.data", cpu_rsp.data, rsp_e.data);
				check("mem_req count", miss_seen, rsp_e.miss);
				if (rsp_e.miss)
					check("refill delay", cyc - last_beat_cyc, 2);
				else
					check("hit delay", cyc - rsp_e.req_cyc, 2);
				miss_seen = 0;
			end
		end
	end

	initial begin
		addr_t a;
		void'($urandom(SEED));
		rst_n = 1'b0;
		flush = 1'b0;
		cpu_req = '0;
		mem_beat = '0;
		cyc = '0;
		last_beat_cyc = '0;
		errors = 0;
		checks = 0;
		miss_seen = 0;
		beats_left = 0;
		gap = 0;
		for (int s = 0; s < SETS; s++) begin
			m_valid[s] = 2'b00;
			m_lru[s] = 1'b0;
		end
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		repeat (3) @(negedge clk);  // quiet after reset

		// cold lines, then the same lines again
		for (int i = 0; i < 4; i++)
			access(BASE + i * 40);
		for (int i = 0; i < 4; i++)
			access(BASE + i * 40);

		// three tags fighting over one set
		access(set_addr(0));
		access(set_addr(1));
		access(set_addr(0));
		access(set_addr(2));
		access(set_addr(1));
		access(set_addr(0));
		access(set_addr(2));

		do_flush();
		access(set_addr(2));
		access(BASE);

		// small pool so lines get reused
		for (int i = 0; i < 300; i++) begin
			if ($urandom_range(0, 49) == 0)
				do_flush();
			if (i % 8 == 7)
				a = {$urandom, $urandom};
			else
				a = {tag_t'($urandom_range(0, 5)) ^ 52'hc_0de0_0000_0000,
					index_t'($urandom_range(0, 7) * 16), 5'($urandom_range(0, 31))};
			access(a);
		end

		repeat (4) @(negedge clk);
		if (exp_q.size() != 0) begin
			$display("%0d responses never arrived", exp_q.size());
			errors++;
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- all.f
verilog/icache_cfg_pkg.sv
verilog/icache_bus_pkg.sv
verilog/icache_ctrl.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_refill.sv
verilog/icache_top.sv
verification/icache_props.sv
verification/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  # packages first, then the RTL
  - verilog/icache_cfg_pkg.sv
  - verilog/icache_bus_pkg.sv
  - verilog/icache_ctrl.sv
  - verilog/icache_tag_array.sv
  - verilog/icache_data_array.sv
  - verilog/icache_refill.sv
  - verilog/icache_top.sv
  - target: test
    files:
      - verification/icache_props.sv
      - verification/icache_tb.sv
